/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ula48_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

# the log search decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* fetchControl.sv */
module fetchControl (
   input  logic           sysclk,
   input  logic           rst_n,
   input  logic           pixelEn,
   input  ulaPkg::rasterT hcnt,
   input  ulaPkg::rasterT vcnt,
   output logic           bitmapLoad,
   output logic           attrLoad,
   output logic           serLoad,
   output logic           attrOutLoad,
   output logic           videoEn,
   output logic           fetching,
   output ulaPkg::vaddrT  vramAddr
);

   logic       paperArea;
   logic       bitmapSlot;
   logic       attrSlot;
   // character column being fetched
   logic [4:0] column;

   ////////////////////////////////////////
   // area decode
   ////////////////////////////////////////

   // fetch window, hc 0 to 255 on lines 0 to 191
   assign paperArea = (hcnt < ulaPkg::paperW) && (vcnt < ulaPkg::paperH);

   // display window runs 8 clocks behind the fetch window
   assign videoEn = (hcnt >= 9'd8) && (hcnt < ulaPkg::paperW + 9'd8) &&
                    (vcnt < ulaPkg::paperH);

   ////////////////////////////////////////
   // fetch slots
   ////////////////////////////////////////

   // second half of each 16-clock group fetches two columns
   // slots 8 9 12 13 bitmap, 10 11 14 15 attribute
   assign bitmapSlot = paperArea && hcnt[3] && !hcnt[1];
   assign attrSlot   = paperArea && hcnt[3] && hcnt[1];

   // data is valid on the odd count of each address pair
   assign bitmapLoad = bitmapSlot && hcnt[0];
   assign attrLoad   = attrSlot && hcnt[0];
   assign fetching   = bitmapSlot || attrSlot;

   // once per character cell
   assign attrOutLoad = (hcnt[2:0] == 3'd4);
   assign serLoad     = attrOutLoad && videoEn;

   // column register, loaded at hc low bits 3
   // ready for the bitmap slot that follows
   always_ff @(posedge sysclk) begin
      if (!rst_n)
         column <= '0;
      else if (pixelEn && (hcnt[2:0] == 3'd3))
         column <= hcnt[7:3];
   end

   ////////////////////////////////////////
   // vram address
   ////////////////////////////////////////

   always_comb begin
      vramAddr = '0;
      if (bitmapSlot) begin
         // 48K interleave: third, pixel row, char row, column
         vramAddr = {1'b0, vcnt[7:6], vcnt[2:0], vcnt[5:3], column};
      end else if (attrSlot) begin
         // attribute map at 6144, 32 bytes per char row
         vramAddr = {4'b0110, vcnt[7:3], column};
      end
   end

endmodule

/* filelist.f */
ulaPkg.sv
rasterCounter.sv
fetchControl.sv
pixelPath.sv
portIo.sv
ula48.sv
ula48_chk.sv
ula48_tb.sv

/* pixelPath.sv */
module pixelPath (
   input  logic          sysclk,
   input  logic          rst_n,
   input  logic          pixelEn,
   input  logic          bitmapLoad,
   input  logic          attrLoad,
   input  logic          serLoad,
   input  logic          attrOutLoad,
   input  logic          videoEn,
   input  ulaPkg::byteT  vramData,
   input  ulaPkg::colT   border,
   output ulaPkg::colT   r,
   output ulaPkg::colT   g,
   output ulaPkg::colT   b
);

   ulaPkg::byteT bitmapData;
   ulaPkg::byteT attrData;
   ulaPkg::byteT serializer;
   ulaPkg::byteT attrOut;
   ulaPkg::byteT attrNext;
   ulaPkg::igrbT pixColour;
   ulaPkg::colT  level;
   logic         serialBit;

   ////////////////////////////////////////
   // fetched byte latches
   ////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (pixelEn && bitmapLoad)
         bitmapData <= vramData;
      if (pixelEn && attrLoad)
         attrData <= vramData;
   end

   ////////////////////////////////////////
   // serializer and attribute output
   ////////////////////////////////////////

   // border shows as paper colour with ink and bright clear
   assign attrNext = videoEn ? attrData : {2'b00, border, 3'b000};

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         serializer <= '0;
         attrOut    <= '0;
      end else if (pixelEn) begin
         // msb first, zeros shift in behind the last pixel
         if (serLoad)
            serializer <= bitmapData;
         else
            serializer <= {serializer[6:0], 1'b0};
         if (attrOutLoad)
            attrOut <= attrNext;
      end
   end

   assign serialBit = serializer[7];

   ////////////////////////////////////////
   // colour table
   ////////////////////////////////////////

   // ink for a set bit, paper for a clear one
   // bit 7 is flash, not supported here
   assign pixColour = serialBit ? {attrOut[6], attrOut[2:0]} :
                                  {attrOut[6], attrOut[5:3]};

   // bright lifts every lit channel to full level
   assign level = pixColour[3] ? ulaPkg::colFull : ulaPkg::colHalf;

   // igrb order is g r b from bit 2 down
   // an unlit channel stays at colNone so black is black with bright set
   assign g = pixColour[2] ? level : ulaPkg::colNone;
   assign r = pixColour[1] ? level : ulaPkg::colNone;
   assign b = pixColour[0] ? level : ulaPkg::colNone;

endmodule

/* portIo.sv */
module portIo (
   input  logic         sysclk,
   input  logic         rst_n,
   input  logic [15:0]  a,
   input  logic         iorqN,
   input  logic         rdN,
   input  logic         wrN,
   input  ulaPkg::byteT din,
   input  logic         ear,
   input  logic [4:0]   kbd,
   input  logic         issue2,
   input  logic         fetching,
   input  ulaPkg::byteT vramData,
   output ulaPkg::colT  border,
   output logic         mic,
   output logic         spk,
   output ulaPkg::byteT dout
);

   logic portWrite;
   logic portRead;
   logic earBit;

   // ula answers every even port, only a0 is decoded
   assign portWrite = !iorqN && !wrN && !a[0];
   assign portRead  = !iorqN && !rdN;

   ////////////////////////////////////////
   // port FE write register
   ////////////////////////////////////////

   // level sensitive, repeats every clock the write is held
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         border <= ulaPkg::borderReset;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (portWrite) begin
         border <= din[2:0];
         mic    <= din[3];
         spk    <= din[4];
      end
   end

   ////////////////////////////////////////
   // read multiplexer
   ////////////////////////////////////////

   // issue 2 boards also hear mic on the ear input
   assign earBit = issue2 ? (ear ^ (spk | mic)) : (ear ^ spk);

   always_comb begin
      dout = ulaPkg::busIdle;
      if (portRead) begin
         if (!a[0])
            dout = {1'b1, earBit, 1'b1, kbd};
         else if (fetching)
            // floating bus shows the byte the ula is fetching
            dout = vramData;
      end
   end

endmodule

/* rasterCounter.sv */
module rasterCounter (
   input  logic           sysclk,
   input  logic           rst_n,
   input  logic           pixelEn,
   output ulaPkg::rasterT hcnt,
   output ulaPkg::rasterT vcnt,
   output logic           hsync,
   output logic           vsync,
   output logic           intN
);

   // counts for the next pixel clock
   ulaPkg::rasterT hNext;
   ulaPkg::rasterT vNext;
   logic           lineEnd;

   // last pixel clock of the line
   assign lineEnd = (hcnt == ulaPkg::lineLen - 9'd1);

   always_comb begin
      hNext = hcnt + 9'd1;
      vNext = vcnt;
      if (lineEnd) begin
         hNext = '0;
         // vertical count steps only on the horizontal wrap
         if (vcnt == ulaPkg::frameLines - 9'd1)
            vNext = '0;
         else
            vNext = vcnt + 9'd1;
      end
   end

   // sync and interrupt decoded from the next counts
   // so the registered levels line up with hcnt and vcnt
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         hcnt  <= '0;
         vcnt  <= '0;
         hsync <= 1'b0;
         vsync <= 1'b0;
         intN  <= 1'b1;
      end else if (pixelEn) begin
         hcnt  <= hNext;
         vcnt  <= vNext;
         hsync <= (hNext >= ulaPkg::hsyncBeg) && (hNext <= ulaPkg::hsyncEnd);
         vsync <= (vNext >= ulaPkg::vsyncBeg) && (vNext <= ulaPkg::vsyncEnd);
         // interrupt at the start of the first vsync line
         intN  <= !((vNext == ulaPkg::vsyncBeg) && (hNext < ulaPkg::intLen));
      end
   end

endmodule

/* ula48.sv */
module ula48 (
   input  logic           sysclk,
   input  logic           rst_n,
   input  logic           pixelEn,
   // cpu side
   input  logic [15:0]    a,
   input  logic           iorqN,
   input  logic           rdN,
   input  logic           wrN,
   input  ulaPkg::byteT   din,
   output ulaPkg::byteT   dout,
   // keyboard, tape and sound
   input  logic           ear,
   input  logic [4:0]     kbd,
   input  logic           issue2,
   output logic           mic,
   output logic           spk,
   // video ram
   output ulaPkg::vaddrT  vramAddr,
   input  ulaPkg::byteT   vramData,
   // video out
   output ulaPkg::colT    r,
   output ulaPkg::colT    g,
   output ulaPkg::colT    b,
   output ulaPkg::rasterT hcnt,
   output ulaPkg::rasterT vcnt,
   output logic           hsync,
   output logic           vsync,
   output logic           intN
);

   // control unit to datapath
   logic        bitmapLoad;
   logic        attrLoad;
   logic        serLoad;
   logic        attrOutLoad;
   logic        videoEn;
   // control unit to cpu interface
   logic        fetching;
   // cpu interface to datapath
   ulaPkg::colT border;

   ////////////////////////////////////////
   // timing
   ////////////////////////////////////////

   rasterCounter i_raster (
      .sysclk  (sysclk),
      .rst_n   (rst_n),
      .pixelEn (pixelEn),
      .hcnt    (hcnt),
      .vcnt    (vcnt),
      .hsync   (hsync),
      .vsync   (vsync),
      .intN    (intN)
   );

   ////////////////////////////////////////
   // control unit
   ////////////////////////////////////////

   fetchControl i_fetch (
      .sysclk      (sysclk),
      .rst_n       (rst_n),
      .pixelEn     (pixelEn),
      .hcnt        (hcnt),
      .vcnt        (vcnt),
      .bitmapLoad  (bitmapLoad),
      .attrLoad    (attrLoad),
      .serLoad     (serLoad),
      .attrOutLoad (attrOutLoad),
      .videoEn     (videoEn),
      .fetching    (fetching),
      .vramAddr    (vramAddr)
   );

   ////////////////////////////////////////
   // datapath
   ////////////////////////////////////////

   pixelPath i_pixel (
      .sysclk      (sysclk),
      .rst_n       (rst_n),
      .pixelEn     (pixelEn),
      .bitmapLoad  (bitmapLoad),
      .attrLoad    (attrLoad),
      .serLoad     (serLoad),
      .attrOutLoad (attrOutLoad),
      .videoEn     (videoEn),
      .vramData    (vramData),
      .border      (border),
      .r           (r),
      .g           (g),
      .b           (b)
   );

   ////////////////////////////////////////
   // cpu interface
   ////////////////////////////////////////

   portIo i_port (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .a        (a),
      .iorqN    (iorqN),
      .rdN      (rdN),
      .wrN      (wrN),
      .din      (din),
      .ear      (ear),
      .kbd      (kbd),
      .issue2   (issue2),
      .fetching (fetching),
      .vramData (vramData),
      .border   (border),
      .mic      (mic),
      .spk      (spk),
      .dout     (dout)
   );

endmodule

/* ula48_chk.sv */
module ula48_chk (
   input logic           sysclk,
   input logic           rst_n,
   input ulaPkg::rasterT hcnt,
   input ulaPkg::rasterT vcnt,
   input logic           hsync,
   input logic           intN,
   input ulaPkg::vaddrT  vramAddr
);

   logic fetchSlot;

   // second half of each 16-count group inside the paper area
   assign fetchSlot = (hcnt < ulaPkg::paperW) && (vcnt < ulaPkg::paperH) && hcnt[3];

   ////////////////////////////////////////
   // raster properties
   ////////////////////////////////////////

   // frame interrupt only on the first vsync line
   intOnVsyncLine: assert property (@(posedge sysclk) disable iff (!rst_n)
      !intN |-> (vcnt == ulaPkg::vsyncBeg))
      else $error("intN low on line %0d", vcnt);

   // hsync never leaks out of its window
   hsyncInWindow: assert property (@(posedge sysclk) disable iff (!rst_n)
      hsync |-> ((hcnt >= ulaPkg::hsyncBeg) && (hcnt <= ulaPkg::hsyncEnd)))
      else $error("hsync high at hcnt %0d", hcnt);

   ////////////////////////////////////////
   // fetch properties
   ////////////////////////////////////////

   // address bus parked at zero between fetches
   addrIdle: assert property (@(posedge sysclk) disable iff (!rst_n)
      !fetchSlot |-> (vramAddr == '0))
      else $error("vramAddr %h outside a fetch slot", vramAddr);

endmodule

/* ula48_tb.sv */
module ula48_tb;

   ////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////

   typedef enum int {
      kindWrite, kindRead, kindFloat, kindAddr, kindPixel, kindSync, kindBorder
   } kindT;

   typedef struct {
      string          name;
      kindT           kind;
      logic [15:0]    port;
      ulaPkg::byteT   data;
      logic           ear;
      logic           issue2;
      ulaPkg::rasterT x;
      ulaPkg::rasterT y;
      // border colour as octal digits g r b
      logic [8:0]     expGrb;
   } stepT;

   stepT steps[$];

   // dut inputs
   logic           sysclk = 1'b0;
   logic           rst_n;
   logic           pixelEn;
   logic [15:0]    a;
   logic           iorqN;
   logic           rdN;
   logic           wrN;
   ulaPkg::byteT   din;
   logic           ear;
   logic [4:0]     kbd;
   logic           issue2;
   ulaPkg::byteT   vramData;
   // dut outputs
   ulaPkg::byteT   dout;
   logic           mic;
   logic           spk;
   ulaPkg::vaddrT  vramAddr;
   ulaPkg::colT    r;
   ulaPkg::colT    g;
   ulaPkg::colT    b;
   ulaPkg::rasterT hcnt;
   ulaPkg::rasterT vcnt;
   logic           hsync;
   logic           vsync;
   logic           intN;

   // run bookkeeping
   int    seed = 69;
   int    cycles = 0;
   int    cycleLimit = 0;
   int    errors = 0;
   int    passCount = 0;
   int    failCount = 0;
   string curName;
   // expected port FE output levels, follow each write
   logic  micModel = 1'b0;
   logic  spkModel = 1'b0;

   ula48 i_dut (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .pixelEn  (pixelEn),
      .a        (a),
      .iorqN    (iorqN),
      .rdN      (rdN),
      .wrN      (wrN),
      .din      (din),
      .dout     (dout),
      .ear      (ear),
      .kbd      (kbd),
      .issue2   (issue2),
      .mic      (mic),
      .spk      (spk),
      .vramAddr (vramAddr),
      .vramData (vramData),
      .r        (r),
      .g        (g),
      .b        (b),
      .hcnt     (hcnt),
      .vcnt     (vcnt),
      .hsync    (hsync),
      .vsync    (vsync),
      .intN     (intN)
   );

   // raster checks on the counter, the address check on the control unit
   bind rasterCounter ula48_chk i_rasterChk (
      .sysclk (sysclk), .rst_n (rst_n), .hcnt (hcnt), .vcnt (vcnt),
      .hsync (hsync), .intN (intN), .vramAddr (14'd0)
   );
   bind fetchControl ula48_chk i_fetchChk (
      .sysclk (sysclk), .rst_n (rst_n), .hcnt (hcnt), .vcnt (vcnt),
      .hsync (1'b0), .intN (1'b1), .vramAddr (vramAddr)
   );

   always #4 sysclk = ~sysclk;

   always @(posedge sysclk) begin
      cycles <= cycles + 1;
      if (cycleLimit != 0 && cycles >= cycleLimit) begin
         $display("Timeout: %0d cycles passed and the tests did not finish", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // vram model and expected values
   ////////////////////////////////////////

   // low byte xor high byte moved up two bits
   function automatic ulaPkg::byteT vramModel(ulaPkg::vaddrT addr);
      return addr[7:0] ^ {addr[13:8], 2'b00};
   endfunction

   assign vramData = vramModel(vramAddr);

   // 48K interleave: 2K per third, 256 per pixel row, 32 per char row
   function automatic ulaPkg::vaddrT bitmapAddr(ulaPkg::rasterT y, logic [4:0] col);
      return ulaPkg::vaddrT'(2048 * y[7:6] + 256 * y[2:0] + 32 * y[5:3] + col);
   endfunction

   // 6144 + 32 * char row + column
   function automatic ulaPkg::vaddrT attrAddr(ulaPkg::rasterT y, logic [4:0] col);
      return 14'd6144 + {4'd0, y[7:3], 5'd0} + {9'd0, col};
   endfunction

   function automatic logic isSlot(ulaPkg::rasterT x, ulaPkg::rasterT y);
      return (x < 9'd256) && (y < 9'd192) && x[3];
   endfunction

   function automatic ulaPkg::vaddrT slotAddr(ulaPkg::rasterT x, ulaPkg::rasterT y);
      ulaPkg::rasterT shifted;
      logic [4:0]     col;
      // column register was loaded at the last count ending in 3
      shifted = x - 9'd4;
      col = shifted[7:3];
      if (!isSlot(x, y))
         return '0;
      // slots 8 9 12 13 bitmap, 10 11 14 15 attribute
      return x[1] ? attrAddr(y, col) : bitmapAddr(y, col);
   endfunction

   function automatic logic [8:0] grbOf(ulaPkg::igrbT c);
      ulaPkg::colT lvl;
      lvl = c[3] ? ulaPkg::colFull : ulaPkg::colHalf;
      return {c[2] ? lvl : ulaPkg::colNone, c[1] ? lvl : ulaPkg::colNone,
              c[0] ? lvl : ulaPkg::colNone};
   endfunction

   // hsync, vsync and intN levels at a raster position
   function automatic logic [2:0] syncOf(ulaPkg::rasterT x, ulaPkg::rasterT y);
      logic hs;
      logic vs;
      logic irq;
      hs = (x >= ulaPkg::hsyncBeg) && (x <= ulaPkg::hsyncEnd);
      vs = (y >= ulaPkg::vsyncBeg) && (y <= ulaPkg::vsyncEnd);
      // interrupt for the first intLen clocks of the first vsync line
      irq = (y == ulaPkg::vsyncBeg) && (x < ulaPkg::intLen);
      return {hs, vs, !irq};
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic checkByte(ulaPkg::byteT expVal, ulaPkg::byteT actVal);
      if (expVal !== actVal) begin
         $display("Mismatch %s: expected %h, actual %h", curName, expVal, actVal);
         errors++;
      end
   endtask

   task automatic checkAddr(ulaPkg::vaddrT expVal, ulaPkg::vaddrT actVal);
      if (expVal !== actVal) begin
         $display("Mismatch %s: expected %h, actual %h", curName, expVal, actVal);
         errors++;
      end
   endtask

   task automatic checkColour(ulaPkg::colT expG, ulaPkg::colT expR, ulaPkg::colT expB,
                              ulaPkg::colT actG, ulaPkg::colT actR, ulaPkg::colT actB);
      if ({expG, expR, expB} !== {actG, actR, actB}) begin
         $display("Mismatch %s: expected g%0d r%0d b%0d, actual g%0d r%0d b%0d",
                  curName, expG, expR, expB, actG, actR, actB);
         errors++;
      end
   endtask

   // spk over mic
   task automatic checkLevels(logic [1:0] expVal, logic [1:0] actVal);
      if (expVal !== actVal) begin
         $display("Mismatch %s: expected %b, actual %b", curName, expVal, actVal);
         errors++;
      end
   endtask

   // hsync, vsync, intN from the top bit down
   task automatic checkSync(logic [2:0] expVal, logic [2:0] actVal);
      if (expVal !== actVal) begin
         $display("Mismatch %s: expected %b, actual %b", curName, expVal, actVal);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // bus and raster helpers
   ////////////////////////////////////////

   // returns 1 unit after the edge that brings hcnt to x
   task automatic waitPos(ulaPkg::rasterT x, ulaPkg::rasterT y, logic anyLine);
      do begin
         @(posedge sysclk);
         #1;
      end while (!(hcnt == x && (anyLine || vcnt == y)));
   endtask

   // one clock of iorq and wr, called 1 unit after an edge
   task automatic busWrite(logic [15:0] port, ulaPkg::byteT data);
      a = port;
      din = data;
      iorqN = 1'b0;
      wrN = 1'b0;
      @(posedge sysclk);
      #1;
      iorqN = 1'b1;
      wrN = 1'b1;
      a = 16'hFFFF;
   endtask

   // dout sampled mid cycle
   task automatic busRead(logic [15:0] port, logic earIn, logic iss, logic [4:0] keys,
                          output ulaPkg::byteT val);
      a = port;
      ear = earIn;
      issue2 = iss;
      kbd = keys;
      iorqN = 1'b0;
      rdN = 1'b0;
      #3;
      val = dout;
      @(posedge sysclk);
      #1;
      iorqN = 1'b1;
      rdN = 1'b1;
      a = 16'hFFFF;
   endtask

   function automatic void addStep(string name, kindT kind, logic [15:0] port,
                                   ulaPkg::byteT data, logic earIn, logic iss,
                                   ulaPkg::rasterT x, ulaPkg::rasterT y, logic [8:0] grb);
      stepT s;
      s.name = name;
      s.kind = kind;
      s.port = port;
      s.data = data;
      s.ear = earIn;
      s.issue2 = iss;
      s.x = x;
      s.y = y;
      s.expGrb = grb;
      steps.push_back(s);
   endfunction

   ////////////////////////////////////////
   // one table entry
   ////////////////////////////////////////

   task automatic runStep(stepT s);
      ulaPkg::byteT expByte;
      ulaPkg::byteT got;
      ulaPkg::byteT bm;
      ulaPkg::byteT at;
      ulaPkg::igrbT c;
      logic [8:0]   grb;
      logic         bitVal;
      int           rnd;
      curName = s.name;
      errors = 0;
      case (s.kind)
         kindWrite: begin
            @(posedge sysclk);
            #1;
            busWrite(s.port, s.data);
            micModel = s.data[3];
            spkModel = s.data[4];
            checkLevels({s.data[4], s.data[3]}, {spk, mic});
         end
         kindRead: begin
            @(posedge sysclk);
            #1;
            rnd = $random(seed);
            // issue 2 boards mix mic into the ear bit
            expByte = {1'b1, s.ear ^ (s.issue2 ? (spkModel | micModel) : spkModel),
                       1'b1, rnd[4:0]};
            busRead(s.port, s.ear, s.issue2, rnd[4:0], got);
            checkByte(expByte, got);
         end
         kindFloat: begin
            expByte = isSlot(s.x, s.y) ? vramModel(slotAddr(s.x, s.y)) : 8'hFF;
            waitPos(s.x, s.y, 1'b0);
            busRead(s.port, 1'b0, 1'b0, 5'h1F, got);
            checkByte(expByte, got);
         end
         kindAddr: begin
            waitPos(s.x, s.y, 1'b0);
            #3;
            checkAddr(slotAddr(s.x, s.y), vramAddr);
         end
         kindPixel: begin
            bm = vramModel(bitmapAddr(s.y, s.x[7:3]));
            at = vramModel(attrAddr(s.y, s.x[7:3]));
            // msb is the leftmost pixel, ink for a set bit
            bitVal = bm[3'd7 - s.x[2:0]];
            c = bitVal ? {at[6], at[2:0]} : {at[6], at[5:3]};
            grb = grbOf(c);
            waitPos(s.x + ulaPkg::pixelLag, s.y, 1'b0);
            #3;
            checkColour(grb[8:6], grb[5:3], grb[2:0], g, r, b);
         end
         kindSync: begin
            waitPos(s.x, s.y, 1'b0);
            #3;
            checkSync(syncOf(s.x, s.y), {hsync, vsync, intN});
         end
         default: begin
            // last attribute load of the line picks up the border
            waitPos(9'd440, 9'd0, 1'b1);
            waitPos(9'd0, 9'd0, 1'b1);
            #3;
            checkColour(s.expGrb[8:6], s.expGrb[5:3], s.expGrb[2:0], g, r, b);
         end
      endcase
      if (errors == 0) begin
         passCount++;
         $display("ok    %s", s.name);
      end else begin
         failCount++;
         $display("fail  %s", s.name);
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      rst_n = 1'b0;
      pixelEn = 1'b1;
      a = 16'hFFFF;
      iorqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      din = 8'h00;
      ear = 1'b0;
      kbd = 5'h1F;
      issue2 = 1'b0;

      // border colours through the igrb table
      addStep("border reset red", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o050);
      addStep("write black", kindWrite, 16'hFEFE, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border black", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o000);
      addStep("write blue", kindWrite, 16'hFEFE, 8'h01, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border blue", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o005);
      addStep("write green", kindWrite, 16'h00FE, 8'h04, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border green", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o500);
      addStep("write white", kindWrite, 16'hFEFE, 8'h07, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border white", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o555);
      addStep("write magenta", kindWrite, 16'h7FFE, 8'h03, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border magenta", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o055);
      addStep("write yellow", kindWrite, 16'hFEFE, 8'h06, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border yellow", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o550);
      // mic and speaker levels into the ear bit
      addStep("write mic", kindWrite, 16'hFEFE, 8'h0A, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("read issue2 mic", kindRead, 16'hFEFE, 8'h00, 1'b0, 1'b1, 9'd0, 9'd0, 9'o0);
      addStep("read issue3 mic", kindRead, 16'h7FFE, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("read issue3 ear", kindRead, 16'hFEFE, 8'h00, 1'b1, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("write spk cyan", kindWrite, 16'hFEFE, 8'h15, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("border cyan", kindBorder, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o505);
      addStep("read issue2 spk", kindRead, 16'hFEFE, 8'h00, 1'b1, 1'b1, 9'd0, 9'd0, 9'o0);
      addStep("read issue3 spk", kindRead, 16'hBFFE, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("write mic spk", kindWrite, 16'hFEFE, 8'h18, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("read issue2 both", kindRead, 16'hFEFE, 8'h00, 1'b1, 1'b1, 9'd0, 9'd0, 9'o0);
      // vram address at chosen slots
      addStep("addr bitmap 8 0", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd8, 9'd0, 9'o0);
      addStep("addr attr 11 0", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd11, 9'd0, 9'o0);
      addStep("addr bitmap 13 70", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd13, 9'd70, 9'o0);
      addStep("addr attr 14 70", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd14, 9'd70, 9'o0);
      addStep("addr bitmap 248 191", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd248, 9'd191, 9'o0);
      addStep("addr attr 255 191", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd255, 9'd191, 9'o0);
      addStep("addr idle 4 10", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd4, 9'd10, 9'o0);
      addStep("addr idle 300 50", kindAddr, 16'h0, 8'h00, 1'b0, 1'b0, 9'd300, 9'd50, 9'o0);
      // floating bus on an odd port
      addStep("float bitmap 9 100", kindFloat, 16'h40FF, 8'h00, 1'b0, 1'b0, 9'd9, 9'd100, 9'o0);
      addStep("float attr 14 100", kindFloat, 16'h40FF, 8'h00, 1'b0, 1'b0, 9'd14, 9'd100, 9'o0);
      addStep("float idle 5 100", kindFloat, 16'h40FF, 8'h00, 1'b0, 1'b0, 9'd5, 9'd100, 9'o0);
      addStep("float idle 9 250", kindFloat, 16'h40FF, 8'h00, 1'b0, 1'b0, 9'd9, 9'd250, 9'o0);
      // sync and interrupt levels around their window edges
      addStep("sync int on 0 248", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd248, 9'o0);
      addStep("sync int end 63 248", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd63, 9'd248, 9'o0);
      addStep("sync int off 64 248", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd64, 9'd248, 9'o0);
      addStep("sync both 344 250", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd344, 9'd250, 9'o0);
      addStep("sync both 375 251", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd375, 9'd251, 9'o0);
      addStep("sync vs 376 251", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd376, 9'd251, 9'o0);
      addStep("sync none 10 252", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd10, 9'd252, 9'o0);
      addStep("sync hs 360 100", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd360, 9'd100, 9'o0);
      addStep("sync none 343 247", kindSync, 16'h0, 8'h00, 1'b0, 1'b0, 9'd343, 9'd247, 9'o0);
      // paper pixels against the vram model
      addStep("pixel 0 0", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd0, 9'd0, 9'o0);
      addStep("pixel 7 0", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd7, 9'd0, 9'o0);
      addStep("pixel 100 37", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd100, 9'd37, 9'o0);
      addStep("pixel 131 85", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd131, 9'd85, 9'o0);
      addStep("pixel 64 128", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd64, 9'd128, 9'o0);
      addStep("pixel 200 150", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd200, 9'd150, 9'o0);
      addStep("pixel 255 191", kindPixel, 16'h0, 8'h00, 1'b0, 1'b0, 9'd255, 9'd191, 9'o0);

      // two frames per entry covers the longest wait for a position
      cycleLimit = steps.size() * 2 * int'(ulaPkg::lineLen) * int'(ulaPkg::frameLines);

      repeat (2) @(posedge sysclk);
      #1;
      rst_n = 1'b1;

      foreach (steps[i])
         runStep(steps[i]);

      $display("%0d tests, %0d passed, %0d failed", steps.size(), passCount, failCount);
      if (failCount == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* ulaPkg.sv */
package ulaPkg;

   ////////////////////////////////////////
   // shared vector types
   ////////////////////////////////////////

   // raster count, wide enough for 448 and 312
   typedef logic [8:0]  rasterT;
   // cpu data byte or vram byte
   typedef logic [7:0]  byteT;
   // 16K video ram address
   typedef logic [13:0] vaddrT;
   // one colour channel, or the 3-bit border value
   typedef logic [2:0]  colT;
   // bright bit on top of g, r, b
   typedef logic [3:0]  igrbT;

   ////////////////////////////////////////
   // raster geometry
   ////////////////////////////////////////

   // pixel clocks per line and lines per frame
   localparam rasterT lineLen    = 9'd448;
   localparam rasterT frameLines = 9'd312;

   // paper area, counted from hc 0 and vc 0
   localparam rasterT paperW = 9'd256;
   localparam rasterT paperH = 9'd192;

   // sync windows, both ends inclusive
   localparam rasterT hsyncBeg = 9'd344;
   localparam rasterT hsyncEnd = 9'd375;
   localparam rasterT vsyncBeg = 9'd248;
   localparam rasterT vsyncEnd = 9'd251;

   // frame interrupt width, starts at hc 0 of the first vsync line
   localparam rasterT intLen = 9'd64;

   // screen column x shows on rgb while hcnt is x + pixelLag
   localparam rasterT pixelLag = 9'd13;

   ////////////////////////////////////////
   // port and colour constants
   ////////////////////////////////////////

   // value of an undriven data bus
   localparam byteT busIdle = 8'hFF;

   // channel levels of the igrb table
   localparam colT colNone = 3'd0;
   localparam colT colHalf = 3'd5;
   localparam colT colFull = 3'd7;

   // red border out of reset
   localparam colT borderReset = 3'd2;

endpackage
